// ==== Bender.yml ====
package:
  name: cpu

sources:
  - files:
      - design/cpuPkg.sv
      - design/instrFetch.sv
      - design/instrDecode.sv
      - design/execute.sv
      - design/hazardUnit.sv
      - design/memStage.sv
      - design/cpu.sv
  - target: test
    files:
      - bench/cpuTb.sv

// ==== bench/cpuTb.sv ====
`timescale 1ns/100ps

module cpuTb;

  localparam int imemAddrW = 8;
  localparam int dmemAddrW = 8;

  logic                 clk;
  logic                 rst_n;
  logic                 imemWe;
  logic [imemAddrW-1:0] imemAddr;
  logic [15:0]          imemData;
  logic [3:0]           dbgAddr;
  logic                 hlt;
  logic [15:0]          pc;
  logic [15:0]          dbgData;

  logic [15:0] prog [$];
  logic [31:0] lcgState = 32'd86;

  cpu #(.imemAddrW(imemAddrW), .dmemAddrW(dmemAddrW)) uut (
    .clk, .rst_n, .imemWe, .imemAddr, .imemData, .dbgAddr, .hlt, .pc, .dbgData
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // ******************************
  // Instruction encoding
  // ******************************
  function automatic logic [15:0] regInstr(input logic [3:0] op, input logic [3:0] rd,
                                           input logic [3:0] rs, input logic [3:0] rt);
    return {op, rd, rs, rt};
  endfunction

  function automatic logic [15:0] immInstr(input logic [3:0] op, input logic [3:0] rd,
                                           input logic [7:0] imm8);
    return {op, rd, imm8};
  endfunction

  function automatic logic [15:0] branchInstr(input logic [2:0] cond,
                                              input logic [8:0] offset9);
    return {4'h7, cond, offset9};
  endfunction

  function automatic logic [15:0] signExtend8(input logic [7:0] v);
    return {{8{v[7]}}, v};
  endfunction

  function automatic logic [15:0] nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[30:15];
  endfunction

  // Condition table on Z, V, N
  function automatic logic condTaken(input logic [2:0] cond, input logic z, input logic v,
                                     input logic n);
    logic taken;
    case (cond)
      3'd0:    taken = !z;
      3'd1:    taken = z;
      3'd2:    taken = !z && !n;
      3'd3:    taken = n;
      3'd4:    taken = !n;
      3'd5:    taken = z || n;
      3'd6:    taken = v;
      default: taken = 1'b1;
    endcase
    return taken;
  endfunction

  // ******************************
  // Checking and control
  // ******************************
  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    if (actual !== expected) begin
      abortRun($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // Reset held over the whole load
  task automatic loadProgram();
    @(negedge clk);
    rst_n = 1'b0;
    for (int i = 0; i < prog.size(); i++) begin
      imemWe   = 1'b1;
      imemAddr = imemAddrW'(i);
      imemData = prog[i];
      @(negedge clk);
    end
    imemWe = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    prog.delete();
  endtask

  task automatic waitHalt();
    int cycles;
    cycles = 0;
    while (!hlt && cycles < 200) begin
      @(negedge clk);
      cycles++;
    end
    if (!hlt) begin
      abortRun("Processor never halted within 200 cycles");
    end
  endtask

  task automatic readReg(input logic [3:0] addr, output logic [15:0] value);
    @(negedge clk);
    dbgAddr = addr;
    #1;
    value = dbgData;
  endtask

  task automatic checkReg(input string name, input logic [3:0] addr,
                          input logic [15:0] expected);
    logic [15:0] value;
    readReg(addr, value);
    checkValue($sformatf("%s r%0d", name, addr), expected, value);
  endtask

  // ******************************
  // Directed tests
  // ******************************
  task automatic aluTest();
    logic [7:0]  a;
    logic [7:0]  b;
    logic [7:0]  c;
    logic [15:0] exp [16];
    for (int round = 0; round < 2; round++) begin
      a = 8'(nextRand());
      b = 8'(nextRand());
      c = 8'(nextRand());
      prog.push_back(immInstr(cpuPkg::opLlb, 4'd1, a));
      prog.push_back(immInstr(cpuPkg::opLlb, 4'd2, b));
      prog.push_back(regInstr(cpuPkg::opAdd, 4'd3, 4'd1, 4'd2));
      prog.push_back(regInstr(cpuPkg::opSub, 4'd4, 4'd3, 4'd1));
      prog.push_back(regInstr(cpuPkg::opAnd, 4'd5, 4'd4, 4'd3));
      prog.push_back(regInstr(cpuPkg::opXor, 4'd6, 4'd5, 4'd2));
      prog.push_back(regInstr(cpuPkg::opAdd, 4'd7, 4'd6, 4'd6));
      prog.push_back(immInstr(cpuPkg::opLlb, 4'd0, c));
      prog.push_back(regInstr(cpuPkg::opAdd, 4'd8, 4'd0, 4'd1));
      prog.push_back(16'hF000);
      exp    = '{default: 16'h0000};
      exp[1] = signExtend8(a);
      exp[2] = signExtend8(b);
      exp[3] = exp[1] + exp[2];
      exp[4] = exp[3] - exp[1];
      exp[5] = exp[4] & exp[3];
      exp[6] = exp[5] ^ exp[2];
      exp[7] = exp[6] + exp[6];
      exp[8] = exp[1];
      loadProgram();
      waitHalt();
      for (int i = 0; i < 9; i++) begin
        checkReg("alu", 4'(i), exp[i]);
      end
    end
  endtask

  task automatic loadStoreTest();
    logic [15:0] v1;
    logic [15:0] v2;
    logic [15:0] v3;
    v1 = signExtend8(8'(nextRand()));
    v2 = signExtend8(8'(nextRand()));
    v3 = signExtend8(8'(nextRand()));
    prog.push_back(immInstr(cpuPkg::opLlb, 4'd1, 8'h20));
    prog.push_back(immInstr(cpuPkg::opLlb, 4'd2, v1[7:0]));
    prog.push_back(immInstr(cpuPkg::opLlb, 4'd3, v2[7:0]));
    prog.push_back(regInstr(cpuPkg::opSw, 4'd2, 4'd1, 4'd0));
    prog.push_back(regInstr(cpuPkg::opSw, 4'd3, 4'd1, 4'd3));
    prog.push_back(regInstr(cpuPkg::opLw, 4'd4, 4'd1, 4'd0));
    prog.push_back(regInstr(cpuPkg::opLw, 4'd5, 4'd1, 4'd3));
    // Load-use on r5
    prog.push_back(regInstr(cpuPkg::opAdd, 4'd6, 4'd5, 4'd4));
    prog.push_back(immInstr(cpuPkg::opLlb, 4'd7, v3[7:0]));
    prog.push_back(regInstr(cpuPkg::opSw, 4'd7, 4'd1, 4'hE));
    prog.push_back(regInstr(cpuPkg::opLw, 4'd8, 4'd1, 4'hE));
    prog.push_back(regInstr(cpuPkg::opLw, 4'd9, 4'd1, 4'd3));
    prog.push_back(regInstr(cpuPkg::opSw, 4'd9, 4'd1, 4'd5));
    prog.push_back(regInstr(cpuPkg::opLw, 4'd10, 4'd1, 4'd5));
    prog.push_back(16'hF000);
    loadProgram();
    waitHalt();
    checkReg("load", 4'd4, v1);
    checkReg("load", 4'd5, v2);
    checkReg("load-use", 4'd6, v1 + v2);
    checkReg("store fwd", 4'd8, v3);
    checkReg("load", 4'd9, v2);
    checkReg("load-store fwd", 4'd10, v2);
  endtask

  task automatic branchCase(input logic [2:0] cond, input logic [7:0] a8,
                            input logic [7:0] b8, input int shift);
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] diff;
    logic        z;
    logic        v;
    logic        n;
    logic        taken;
    string       name;
    x     = signExtend8(a8) << shift;
    y     = signExtend8(b8) << shift;
    diff  = x - y;
    // V and N from SUB, Z from the AND after it
    v     = (x[15] != y[15]) && (diff[15] != x[15]);
    n     = diff[15];
    z     = ((x & y) == 16'h0000);
    taken = condTaken(cond, z, v, n);
    name  = $sformatf("branch cond%0d x=%h y=%h", cond, x, y);
    prog.push_back(immInstr(cpuPkg::opLlb, 4'd1, a8));
    prog.push_back(immInstr(cpuPkg::opLlb, 4'd2, b8));
    for (int i = 0; i < shift; i++) begin
      prog.push_back(regInstr(cpuPkg::opAdd, 4'd1, 4'd1, 4'd1));
      prog.push_back(regInstr(cpuPkg::opAdd, 4'd2, 4'd2, 4'd2));
    end
    prog.push_back(regInstr(cpuPkg::opSub, 4'd3, 4'd1, 4'd2));
    prog.push_back(regInstr(cpuPkg::opAnd, 4'd4, 4'd1, 4'd2));
    prog.push_back(branchInstr(cond, 9'd4));
    for (int r = 5; r < 10; r++) begin
      prog.push_back(immInstr(cpuPkg::opLlb, 4'(r), 8'd1));
    end
    prog.push_back(16'hF000);
    loadProgram();
    waitHalt();
    for (int r = 5; r < 9; r++) begin
      checkReg(name, 4'(r), taken ? 16'h0000 : 16'h0001);
    end
    checkReg(name, 4'd9, 16'h0001);
  endtask

  task automatic sweepConds(input logic [7:0] a8, input logic [7:0] b8, input int shift);
    for (int c = 0; c < 8; c++) begin
      branchCase(3'(c), a8, b8, shift);
    end
  endtask

  task automatic branchTest();
    sweepConds(8'h01, 8'h02, 0);
    sweepConds(8'h04, 8'h03, 0);
    sweepConds(8'h07, 8'h03, 0);
    sweepConds(8'h40, 8'hC0, 8);
    sweepConds(8'h03, 8'h07, 0);
  endtask

  task automatic jumpTest();
    prog.push_back(immInstr(cpuPkg::opLlb, 4'd1, 8'd3));
    prog.push_back(immInstr(cpuPkg::opJal, 4'd15, 8'd3));
    prog.push_back(regInstr(cpuPkg::opAdd, 4'd2, 4'd1, 4'd1));
    prog.push_back(16'hF000);
    prog.push_back(immInstr(cpuPkg::opLlb, 4'd3, 8'h55));
    // Subroutine at 5
    prog.push_back(immInstr(cpuPkg::opLlb, 4'd4, 8'h11));
    prog.push_back(regInstr(cpuPkg::opAdd, 4'd5, 4'd15, 4'd4));
    prog.push_back(regInstr(cpuPkg::opJr, 4'd0, 4'd15, 4'd0));
    for (int r = 6; r < 9; r++) begin
      prog.push_back(immInstr(cpuPkg::opLlb, 4'(r), 8'h22));
    end
    loadProgram();
    waitHalt();
    checkReg("jal link", 4'd15, 16'h0002);
    checkReg("after return", 4'd2, 16'h0006);
    checkReg("skipped", 4'd3, 16'h0000);
    checkReg("subroutine", 4'd5, 16'h0013);
    for (int r = 6; r < 9; r++) begin
      checkReg("jr shadow", 4'(r), 16'h0000);
    end
  endtask

  task automatic haltTest();
    prog.push_back(immInstr(cpuPkg::opLlb, 4'd1, 8'h21));
    prog.push_back(regInstr(cpuPkg::opAdd, 4'd2, 4'd1, 4'd1));
    prog.push_back(16'hF000);
    loadProgram();
    waitHalt();
    repeat (5) begin
      @(negedge clk);
      checkValue("halt level", 16'h0001, {15'd0, hlt});
      checkValue("halt pc", 16'h0002, pc);
    end
    checkReg("halt", 4'd2, 16'h0042);

    // HLT right behind a taken branch
    @(negedge clk);
    dbgAddr = 4'd3;
    prog.push_back(branchInstr(3'd7, 9'd3));
    prog.push_back(16'hF000);
    prog.push_back(immInstr(cpuPkg::opLlb, 4'd2, 8'h33));
    prog.push_back(16'hF000);
    prog.push_back(immInstr(cpuPkg::opLlb, 4'd3, 8'h44));
    prog.push_back(16'hF000);
    loadProgram();
    waitHalt();
    #1;
    checkValue("shadow halt r3", 16'h0044, dbgData);
    checkValue("shadow halt pc", 16'h0005, pc);
    checkReg("shadow halt", 4'd2, 16'h0000);
  endtask

  initial begin
    rst_n    = 1'b0;
    imemWe   = 1'b0;
    imemAddr = '0;
    imemData = '0;
    dbgAddr  = '0;
    repeat (3) @(negedge clk);
    aluTest();
    loadStoreTest();
    branchTest();
    jumpTest();
    haltTest();
    $display("Test OK");
    $finish;
  end

endmodule

// ==== cpu.f ====
design/cpuPkg.sv
design/instrFetch.sv
design/instrDecode.sv
design/execute.sv
design/hazardUnit.sv
design/memStage.sv
design/cpu.sv
bench/cpuTb.sv

// ==== design/cpu.sv ====
`timescale 1ns/100ps

module cpu #(
  parameter int imemAddrW = 8,
  parameter int dmemAddrW = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 imemWe,
  input  logic [imemAddrW-1:0] imemAddr,
  input  logic [15:0]          imemData,
  input  logic [3:0]           dbgAddr,
  output logic                 hlt,
  output logic [15:0]          pc,
  output logic [15:0]          dbgData
);

  cpuPkg::instrU ifInstr;
  cpuPkg::instrU ifIdQ;
  logic [15:0]   ifPcNext;
  logic [15:0]   ifIdPcNext;
  cpuPkg::ctrlS  idCtrl;
  logic [3:0]    idRsAddr;
  logic [3:0]    idRtAddr;
  logic [15:0]   idOpA;
  logic [15:0]   idOpB;
  logic [15:0]   idImm;
  cpuPkg::idExS  idExQ;
  logic [15:0]   exOpA;
  logic [15:0]   exOpB;
  logic [15:0]   exResult;
  logic [15:0]   exTarget;
  cpuPkg::flagsS exFlags;
  cpuPkg::exMemS exMemQ;
  cpuPkg::exMemS memIn;
  logic [15:0]   storeData;
  logic [15:0]   memData;
  logic [15:0]   branchTarget;
  logic          branchTaken;
  cpuPkg::memWbS memWbQ;
  logic [15:0]   wbData;
  logic          stall;
  logic          flush;

  instrFetch #(.imemAddrW(imemAddrW)) fetch (
    .clk, .rst_n, .stall, .flush, .branchTarget, .imemWe, .imemAddr, .imemData,
    .pc, .instr(ifInstr), .pcNext(ifPcNext)
  );

  // ******************************
  // IF/ID
  // ******************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ifIdQ      <= '0;
      ifIdPcNext <= '0;
    end else if (flush) begin
      ifIdQ <= '0;
    end else if (!stall) begin
      ifIdQ      <= ifInstr;
      ifIdPcNext <= ifPcNext;
    end
  end

  instrDecode decode (
    .clk, .rst_n, .instr(ifIdQ), .wbWe(memWbQ.regWe), .wbAddr(memWbQ.rd), .wbData,
    .dbgAddr, .ctrl(idCtrl), .rsAddr(idRsAddr), .rtAddr(idRtAddr), .opA(idOpA),
    .opB(idOpB), .imm(idImm), .dbgData
  );

  // ******************************
  // ID/EX
  // ******************************
  // Bubble on load-use or redirect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idExQ <= '0;
    end else begin
      idExQ <= '{ctrl: idCtrl, pcNext: ifIdPcNext, rsAddr: idRsAddr, rtAddr: idRtAddr,
                 opA: idOpA, opB: idOpB, imm: idImm};
      if (flush || stall) begin
        idExQ.ctrl <= '0;
      end
    end
  end

  hazardUnit hazard (
    .ifId(ifIdQ), .idEx(idExQ), .exMem(exMemQ), .memWb(memWbQ), .branchTaken,
    .opA(idExQ.opA), .opB(idExQ.opB), .exStoreData(exMemQ.storeData),
    .exOpA, .exOpB, .storeData, .stall, .flush
  );

  execute exec (
    .idEx(idExQ), .opA(exOpA), .opB(exOpB), .result(exResult), .target(exTarget),
    .flags(exFlags)
  );

  // ******************************
  // EX/MEM
  // ******************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exMemQ <= '0;
    end else begin
      exMemQ <= '{ctrl: idExQ.ctrl, pcNext: idExQ.pcNext, result: exResult,
                  storeData: exOpB, target: exTarget, flags: exFlags};
      if (flush) begin
        exMemQ.ctrl <= '0;
      end
    end
  end

  // Late store data from the hazard unit
  always_comb begin
    memIn           = exMemQ;
    memIn.storeData = storeData;
  end

  memStage #(.dmemAddrW(dmemAddrW)) mem (
    .clk, .rst_n, .exMem(memIn), .memData, .branchTaken, .branchTarget
  );

  // ******************************
  // MEM/WB and writeback
  // ******************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      memWbQ <= '0;
    end else begin
      memWbQ <= '{regWe: exMemQ.ctrl.regWe, rd: exMemQ.ctrl.rd, hlt: exMemQ.ctrl.hlt,
                  memToReg: exMemQ.ctrl.memToReg, result: exMemQ.result, memData: memData};
    end
  end

  assign wbData = memWbQ.memToReg ? memWbQ.memData : memWbQ.result;
  // HLT keeps refetching, so this level holds once raised
  assign hlt    = memWbQ.hlt;

endmodule

// ==== design/cpuPkg.sv ====
package cpuPkg;

  // Opcode 0 is ADD, so an all-zero word is ADD r0,r0,r0 and acts as NOP
  typedef enum logic [3:0] {
    opAdd = 4'h0,
    opSub = 4'h1,
    opAnd = 4'h2,
    opXor = 4'h3,
    opLlb = 4'h4,
    opLw  = 4'h5,
    opSw  = 4'h6,
    opB   = 4'h7,
    opJal = 4'h8,
    opJr  = 4'h9,
    opHlt = 4'hF
  } opcodeE;

  // Branch conditions, tested against the flag register
  typedef enum logic [2:0] {
    condNe = 3'd0,
    condEq = 3'd1,
    condGt = 3'd2,
    condLt = 3'd3,
    condGe = 3'd4,
    condLe = 3'd5,
    condOv = 3'd6,
    condUn = 3'd7
  } condE;

  // Register format; rt holds the offset for LW and SW
  typedef struct packed {
    opcodeE     opcode;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
  } rFormS;

  // Immediate format for LLB and JAL
  typedef struct packed {
    opcodeE     opcode;
    logic [3:0] rd;
    logic [7:0] imm8;
  } iFormS;

  // Branch format
  typedef struct packed {
    opcodeE     opcode;
    condE       cond;
    logic [8:0] offset9;
  } bFormS;

  typedef union packed {
    rFormS r;
    iFormS i;
    bFormS b;
  } instrU;

  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flagsS;

  typedef struct packed {
    logic       regWe;
    logic       memRe;
    logic       memWe;
    logic       memToReg;
    logic       branch;
    logic       jal;
    logic       jr;
    logic       hlt;
    logic       setZ;
    logic       setVN;
    opcodeE     aluOp;
    condE       cond;
    logic [3:0] rd;
  } ctrlS;

  typedef struct packed {
    ctrlS        ctrl;
    logic [15:0] pcNext;
    logic [3:0]  rsAddr;
    logic [3:0]  rtAddr;
    logic [15:0] opA;
    logic [15:0] opB;
    logic [15:0] imm;
  } idExS;

  typedef struct packed {
    ctrlS        ctrl;
    logic [15:0] pcNext;
    logic [15:0] result;
    logic [15:0] storeData;
    logic [15:0] target;
    flagsS       flags;
  } exMemS;

  typedef struct packed {
    logic        regWe;
    logic [3:0]  rd;
    logic        hlt;
    logic        memToReg;
    logic [15:0] result;
    logic [15:0] memData;
  } memWbS;

endpackage

// ==== design/execute.sv ====
`timescale 1ns/100ps

module execute (
  input  cpuPkg::idExS  idEx,
  input  logic [15:0]   opA,
  input  logic [15:0]   opB,
  output logic [15:0]   result,
  output logic [15:0]   target,
  output cpuPkg::flagsS flags
);

  logic [15:0] sum;
  logic [15:0] diff;
  logic [15:0] addr;
  logic        addOv;
  logic        subOv;

  assign sum  = opA + opB;
  assign diff = opA - opB;
  // Base plus signed offset for LW and SW
  assign addr = opA + idEx.imm;

  // Signed overflow from the operand and result signs
  assign addOv = (opA[15] == opB[15]) && (sum[15] != opA[15]);
  assign subOv = (opA[15] != opB[15]) && (diff[15] != opA[15]);

  always_comb begin
    case (idEx.ctrl.aluOp)
      cpuPkg::opAdd:              result = sum;
      cpuPkg::opSub:              result = diff;
      cpuPkg::opAnd:              result = opA & opB;
      cpuPkg::opXor:              result = opA ^ opB;
      cpuPkg::opLlb:              result = idEx.imm;
      cpuPkg::opLw, cpuPkg::opSw: result = addr;
      // Link value for r15
      cpuPkg::opJal:              result = idEx.pcNext;
      default:                    result = 16'h0000;
    endcase
  end

  always_comb begin
    flags.z = (result == 16'h0000);
    flags.n = result[15];
    case (idEx.ctrl.aluOp)
      cpuPkg::opAdd: flags.v = addOv;
      cpuPkg::opSub: flags.v = subOv;
      default:       flags.v = 1'b0;
    endcase
  end

  // PC-relative for B and JAL, register for JR
  assign target = idEx.ctrl.jr ? opA : idEx.pcNext + idEx.imm;

endmodule

// ==== design/hazardUnit.sv ====
`timescale 1ns/100ps

module hazardUnit (
  input  cpuPkg::instrU ifId,
  input  cpuPkg::idExS  idEx,
  input  cpuPkg::exMemS exMem,
  input  cpuPkg::memWbS memWb,
  input  logic          branchTaken,
  input  logic [15:0]   opA,
  input  logic [15:0]   opB,
  input  logic [15:0]   exStoreData,
  output logic [15:0]   exOpA,
  output logic [15:0]   exOpB,
  output logic [15:0]   storeData,
  output logic          stall,
  output logic          flush
);

  logic [15:0] wbData;
  logic        exMemWr;
  logic        memWbWr;
  logic        loadUse;

  assign wbData  = memWb.memToReg ? memWb.memData : memWb.result;
  // Producers that really write a register other than r0
  assign exMemWr = exMem.ctrl.regWe && (exMem.ctrl.rd != 4'd0);
  assign memWbWr = memWb.regWe && (memWb.rd != 4'd0);

  // Youngest producer first
  function automatic logic [15:0] fwd(input logic [3:0] addr, input logic [15:0] regVal);
    if (exMemWr && exMem.ctrl.rd == addr) begin
      return exMem.result;
    end else if (memWbWr && memWb.rd == addr) begin
      return wbData;
    end
    return regVal;
  endfunction

  always_comb begin
    exOpA = fwd(idEx.rsAddr, opA);
    exOpB = fwd(idEx.rtAddr, opB);
  end

  // Store data fixed up in MEM, covers a load right before the store
  assign storeData = (exMem.ctrl.memWe && memWbWr && memWb.rd == exMem.ctrl.rd) ?
                     wbData : exStoreData;

  // Load in EX feeding the instruction in decode
  assign loadUse = idEx.ctrl.memRe && (idEx.ctrl.rd != 4'd0) &&
                   (idEx.ctrl.rd == ifId.r.rs || idEx.ctrl.rd == ifId.r.rt);

  assign flush = branchTaken;
  assign stall = loadUse && !branchTaken;

endmodule

// ==== design/instrDecode.sv ====
`timescale 1ns/100ps

module instrDecode (
  input  logic          clk,
  input  logic          rst_n,
  input  cpuPkg::instrU instr,
  input  logic          wbWe,
  input  logic [3:0]    wbAddr,
  input  logic [15:0]   wbData,
  input  logic [3:0]    dbgAddr,
  output cpuPkg::ctrlS  ctrl,
  output logic [3:0]    rsAddr,
  output logic [3:0]    rtAddr,
  output logic [15:0]   opA,
  output logic [15:0]   opB,
  output logic [15:0]   imm,
  output logic [15:0]   dbgData
);

  logic [15:0] regs [16];

  // Read with r0 tied low and bypass of the writeback port
  function automatic logic [15:0] rfRead(input logic [3:0] addr);
    if (addr == 4'd0) begin
      return 16'h0000;
    end else if (wbWe && wbAddr == addr) begin
      return wbData;
    end
    return regs[addr];
  endfunction

  // ******************************
  // Control decode
  // ******************************
  always_comb begin
    ctrl       = '0;
    ctrl.aluOp = instr.r.opcode;
    ctrl.cond  = instr.b.cond;
    ctrl.rd    = instr.r.rd;
    rsAddr     = 4'd0;
    rtAddr     = 4'd0;
    imm        = 16'h0000;
    case (instr.r.opcode)
      cpuPkg::opAdd, cpuPkg::opSub: begin
        ctrl.regWe = 1'b1;
        ctrl.setZ  = 1'b1;
        ctrl.setVN = 1'b1;
        rsAddr     = instr.r.rs;
        rtAddr     = instr.r.rt;
      end
      // Logic ops touch only Z
      cpuPkg::opAnd, cpuPkg::opXor: begin
        ctrl.regWe = 1'b1;
        ctrl.setZ  = 1'b1;
        rsAddr     = instr.r.rs;
        rtAddr     = instr.r.rt;
      end
      cpuPkg::opLlb: begin
        ctrl.regWe = 1'b1;
        imm        = {{8{instr.i.imm8[7]}}, instr.i.imm8};
      end
      cpuPkg::opLw: begin
        ctrl.regWe    = 1'b1;
        ctrl.memRe    = 1'b1;
        ctrl.memToReg = 1'b1;
        rsAddr        = instr.r.rs;
        imm           = {{12{instr.r.rt[3]}}, instr.r.rt};
      end
      // Store data comes from the rd field, base from rs
      cpuPkg::opSw: begin
        ctrl.memWe = 1'b1;
        rsAddr     = instr.r.rs;
        rtAddr     = instr.r.rd;
        imm        = {{12{instr.r.rt[3]}}, instr.r.rt};
      end
      cpuPkg::opB: begin
        ctrl.branch = 1'b1;
        imm         = {{7{instr.b.offset9[8]}}, instr.b.offset9};
      end
      cpuPkg::opJal: begin
        ctrl.regWe = 1'b1;
        ctrl.jal   = 1'b1;
        ctrl.rd    = 4'd15;
        imm        = {{8{instr.i.imm8[7]}}, instr.i.imm8};
      end
      cpuPkg::opJr: begin
        ctrl.jr = 1'b1;
        rsAddr  = instr.r.rs;
      end
      cpuPkg::opHlt: ctrl.hlt = 1'b1;
      default: ;
    endcase
  end

  // ******************************
  // Register file
  // ******************************
  always_comb begin
    opA     = rfRead(rsAddr);
    opB     = rfRead(rtAddr);
    dbgData = rfRead(dbgAddr);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= 16'h0000;
      end
    end else if (wbWe && wbAddr != 4'd0) begin
      regs[wbAddr] <= wbData;
    end
  end

  r0StaysZero: assert property (@(posedge clk) disable iff (!rst_n)
    (wbWe && wbAddr == 4'd0) |=> (regs[0] == 16'h0000));

endmodule

// ==== design/instrFetch.sv ====
`timescale 1ns/100ps

module instrFetch #(
  parameter int imemAddrW = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 stall,
  input  logic                 flush,
  input  logic [15:0]          branchTarget,
  input  logic                 imemWe,
  input  logic [imemAddrW-1:0] imemAddr,
  input  logic [15:0]          imemData,
  output logic [15:0]          pc,
  output cpuPkg::instrU        instr,
  output logic [15:0]          pcNext
);

  logic [15:0] imem [2**imemAddrW];
  logic        fetchHlt;

  // Program load port
  always_ff @(posedge clk) begin
    if (imemWe) begin
      imem[imemAddr] <= imemData;
    end
  end

  assign instr    = imem[pc[imemAddrW-1:0]];
  assign pcNext   = pc + 16'd1;
  assign fetchHlt = (instr.r.opcode == cpuPkg::opHlt);

  // Redirect wins over both stall and halt
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (flush) begin
      pc <= branchTarget;
    end else if (!stall && !fetchHlt) begin
      pc <= pcNext;
    end
  end

  // Program writes only under reset or with the PC parked on HLT
  imemWriteIdle: assert property (@(posedge clk) imemWe |-> (!rst_n || fetchHlt));

endmodule

// ==== design/memStage.sv ====
`timescale 1ns/100ps

module memStage #(
  parameter int dmemAddrW = 8
) (
  input  logic          clk,
  input  logic          rst_n,
  input  cpuPkg::exMemS exMem,
  output logic [15:0]   memData,
  output logic          branchTaken,
  output logic [15:0]   branchTarget
);

  logic [15:0]          dmem [2**dmemAddrW];
  logic [dmemAddrW-1:0] addr;
  cpuPkg::flagsS        flagQ;
  logic                 condMet;

  assign addr    = exMem.result[dmemAddrW-1:0];
  assign memData = dmem[addr];

  always_ff @(posedge clk) begin
    if (exMem.ctrl.memWe) begin
      dmem[addr] <= exMem.storeData;
    end
  end

  // Flags load as the instruction leaves MEM
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flagQ <= '0;
    end else begin
      if (exMem.ctrl.setZ) begin
        flagQ.z <= exMem.flags.z;
      end
      if (exMem.ctrl.setVN) begin
        flagQ.v <= exMem.flags.v;
        flagQ.n <= exMem.flags.n;
      end
    end
  end

  always_comb begin
    case (exMem.ctrl.cond)
      cpuPkg::condNe: condMet = !flagQ.z;
      cpuPkg::condEq: condMet = flagQ.z;
      cpuPkg::condGt: condMet = !flagQ.z && !flagQ.n;
      cpuPkg::condLt: condMet = flagQ.n;
      cpuPkg::condGe: condMet = !flagQ.n;
      cpuPkg::condLe: condMet = flagQ.z || flagQ.n;
      cpuPkg::condOv: condMet = flagQ.v;
      cpuPkg::condUn: condMet = 1'b1;
      default:        condMet = 1'b0;
    endcase
  end

  // Jumps always redirect
  assign branchTaken  = (exMem.ctrl.branch && condMet) || exMem.ctrl.jal || exMem.ctrl.jr;
  assign branchTarget = exMem.target;

endmodule
